// File: sources.f
cmac_ctrl_pkg.sv
rx_link_fsm.sv
tx_link_fsm.sv
stat_accumulator.sv
error_counters.sv
cmac_link_ctrl.sv
tb_cmac_link_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cmac_link_ctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_cmac_link_ctrl -f sources.f; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_cmac_link_ctrl)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1

// File: tb_cmac_link_ctrl.sv
`timescale 1ns/1ps

module tb_cmac_link_ctrl;

    localparam int clk_period    = 100;
    localparam int test_cycles   = 60; // all six tests together
    localparam int margin_cycles = 40;

    logic        gt_txusrclk2;
    logic        usr_rx_reset_w;
    logic        core_tx_reset_w;
    logic        stat_rx_aligned;
    logic [2:0]  stat_rx_total_packets;
    logic        stat_rx_good_packets;
    logic [6:0]  stat_rx_total_bytes;
    logic [13:0] stat_rx_good_bytes;
    logic [0:0]  stat_tx_total_packets;
    logic        stat_tx_good_packets;
    logic [5:0]  stat_tx_total_bytes;
    logic [13:0] stat_tx_good_bytes;
    logic        stat_rx_aligned_err;
    logic [2:0]  stat_rx_bad_code;
    logic [2:0]  stat_rx_bad_fcs;
    logic        stat_rx_bad_preamble;
    logic        stat_rx_bad_sfd;
    logic        tx_ovf;
    logic        tx_unf;
    logic        ctl_rx_enable;
    logic        ctl_tx_enable;
    logic        ctl_tx_send_lfi;
    logic        ctl_tx_send_rfi;
    logic [31:0] rx_total_pkts, rx_good_pkts, rx_total_bytes, rx_good_bytes;
    logic [31:0] tx_total_pkts, tx_good_pkts, tx_total_bytes, tx_good_bytes;
    logic [15:0] align_errors, code_errors, fcs_errors, preamble_errors;
    logic [15:0] sfd_errors, overflow_count, underflow_count;

    integer      seed = 35;
    int          error_count = 0;
    int          check_count = 0;
    // expected totals, built from the applied increments
    logic [31:0] exp_rx_tp = '0, exp_rx_gp = '0, exp_rx_tb = '0, exp_rx_gb = '0;
    logic [31:0] exp_tx_tp = '0, exp_tx_gp = '0, exp_tx_tb = '0, exp_tx_gb = '0;
    logic [15:0] exp_align = '0, exp_code = '0, exp_fcs = '0, exp_pre = '0;
    logic [15:0] exp_sfd = '0, exp_ovf = '0, exp_unf = '0;

    cmac_link_ctrl cmac_link_ctrl_inst (.*);

    initial begin
        gt_txusrclk2 = 1'b0;
        forever #(clk_period / 2) gt_txusrclk2 = ~gt_txusrclk2;
    end

    initial begin
        #(clk_period * (test_cycles + margin_cycles));
        $display("timeout: the tests did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

    task automatic step();
        @(posedge gt_txusrclk2);
        #1; // drive and sample just after the edge
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic check_controls(input logic rx_en, input logic tx_en,
                                  input logic lfi, input logic rfi);
        check_value("ctl_rx_enable", {31'd0, ctl_rx_enable}, {31'd0, rx_en});
        check_value("ctl_tx_enable", {31'd0, ctl_tx_enable}, {31'd0, tx_en});
        check_value("ctl_tx_send_lfi", {31'd0, ctl_tx_send_lfi}, {31'd0, lfi});
        check_value("ctl_tx_send_rfi", {31'd0, ctl_tx_send_rfi}, {31'd0, rfi});
    endtask

    task automatic check_totals();
        check_value("rx_total_pkts", rx_total_pkts, exp_rx_tp);
        check_value("rx_good_pkts", rx_good_pkts, exp_rx_gp);
        check_value("rx_total_bytes", rx_total_bytes, exp_rx_tb);
        check_value("rx_good_bytes", rx_good_bytes, exp_rx_gb);
        check_value("tx_total_pkts", tx_total_pkts, exp_tx_tp);
        check_value("tx_good_pkts", tx_good_pkts, exp_tx_gp);
        check_value("tx_total_bytes", tx_total_bytes, exp_tx_tb);
        check_value("tx_good_bytes", tx_good_bytes, exp_tx_gb);
    endtask

    task automatic clear_inputs();
        {stat_rx_total_packets, stat_rx_good_packets, stat_rx_total_bytes} = '0;
        {stat_rx_good_bytes, stat_tx_good_bytes} = '0;
        {stat_tx_total_packets, stat_tx_good_packets, stat_tx_total_bytes} = '0;
        {stat_rx_aligned_err, stat_rx_bad_code, stat_rx_bad_fcs} = '0;
        {stat_rx_bad_preamble, stat_rx_bad_sfd, tx_ovf, tx_unf} = '0;
    endtask

    task automatic reset_and_rx_bringup();
        repeat (5) begin
            step();
            check_controls(0, 0, 0, 0);
        end
        usr_rx_reset_w  = 1'b0;
        core_tx_reset_w = 1'b0;
        step();
        check_controls(0, 0, 0, 0); // edge 0, reset-done sets
        step();
        check_controls(0, 0, 0, 0); // edge 1, gt_locked
        step();
        check_controls(1, 0, 1, 1); // edge 2
    endtask

    task automatic tx_bringup();
        repeat (3) begin
            step();
            check_controls(1, 0, 1, 1); // faults signalled until aligned
        end
        stat_rx_aligned = 1'b1;
        step();
        check_controls(1, 0, 1, 1); // rx_aligned_d rises
        step();
        check_controls(1, 0, 1, 1); // both FSMs now in transfer
        step();
        check_controls(1, 1, 0, 0);
    endtask

    task automatic alignment_loss();
        stat_rx_aligned = 1'b0;
        step();
        check_controls(1, 1, 0, 0); // rx_aligned_d falls
        step();
        check_controls(1, 1, 0, 0); // seen low, back to idle
        step();
        check_controls(0, 0, 0, 0);
        step();
        check_controls(1, 0, 1, 1); // restart sequence
        stat_rx_aligned = 1'b1;
        step();
        check_controls(1, 0, 1, 1);
        step();
        check_controls(1, 0, 1, 1);
        step();
        check_controls(1, 1, 0, 0);
    endtask

    task automatic statistics();
        logic [31:0] rnd;
        for (int i = 0; i < 20; i++) begin
            rnd = $random(seed);
            stat_rx_total_packets = rnd[2:0];
            stat_rx_good_packets  = rnd[3];
            stat_rx_total_bytes   = rnd[10:4];
            stat_tx_total_packets = rnd[11];
            stat_tx_good_packets  = rnd[12];
            stat_tx_total_bytes   = rnd[18:13];
            rnd = $random(seed);
            stat_rx_good_bytes = rnd[13:0];
            stat_tx_good_bytes = rnd[27:14];
            exp_rx_tp += {29'd0, stat_rx_total_packets};
            exp_rx_gp += {31'd0, stat_rx_good_packets};
            exp_rx_tb += {25'd0, stat_rx_total_bytes};
            exp_rx_gb += {18'd0, stat_rx_good_bytes};
            exp_tx_tp += {31'd0, stat_tx_total_packets};
            exp_tx_gp += {31'd0, stat_tx_good_packets};
            exp_tx_tb += {26'd0, stat_tx_total_bytes};
            exp_tx_gb += {18'd0, stat_tx_good_bytes};
            step(); // added at this edge
        end
        clear_inputs();
        check_totals();
    endtask

    task automatic pulse_events(input logic ae, input logic [2:0] code, input logic [2:0] fcs,
                                input logic pre, input logic sfd, input logic ovf,
                                input logic unf);
        stat_rx_aligned_err  = ae;
        stat_rx_bad_code     = code;
        stat_rx_bad_fcs      = fcs;
        stat_rx_bad_preamble = pre;
        stat_rx_bad_sfd      = sfd;
        tx_ovf               = ovf;
        tx_unf               = unf;
        // any nonzero value is one event
        exp_align += {15'd0, ae};
        exp_code  += {15'd0, code != 3'd0};
        exp_fcs   += {15'd0, fcs != 3'd0};
        exp_pre   += {15'd0, pre};
        exp_sfd   += {15'd0, sfd};
        exp_ovf   += {15'd0, ovf};
        exp_unf   += {15'd0, unf};
        step();
        clear_inputs();
    endtask

    task automatic error_events();
        pulse_events(1, 3'b000, 3'b000, 0, 0, 0, 0);
        pulse_events(0, 3'b001, 3'b110, 1, 0, 0, 0);
        pulse_events(1, 3'b111, 3'b000, 0, 1, 1, 0);
        step(); // quiet cycle
        pulse_events(0, 3'b100, 3'b011, 1, 1, 0, 1);
        pulse_events(0, 3'b000, 3'b010, 0, 0, 1, 1);
        pulse_events(1, 3'b010, 3'b000, 0, 0, 1, 0);
        check_value("align_errors", {16'd0, align_errors}, {16'd0, exp_align});
        check_value("code_errors", {16'd0, code_errors}, {16'd0, exp_code});
        check_value("fcs_errors", {16'd0, fcs_errors}, {16'd0, exp_fcs});
        check_value("preamble_errors", {16'd0, preamble_errors}, {16'd0, exp_pre});
        check_value("sfd_errors", {16'd0, sfd_errors}, {16'd0, exp_sfd});
        check_value("overflow_count", {16'd0, overflow_count}, {16'd0, exp_ovf});
        check_value("underflow_count", {16'd0, underflow_count}, {16'd0, exp_unf});
    endtask

    task automatic tx_clear();
        core_tx_reset_w = 1'b1;
        {exp_tx_tp, exp_tx_gp, exp_tx_tb, exp_tx_gb} = '0; // tx side only
        repeat (2) begin
            step();
            check_controls(1, 0, 0, 0);
            check_totals();
            check_value("align_errors", {16'd0, align_errors}, {16'd0, exp_align});
        end
        core_tx_reset_w = 1'b0;
    endtask

    initial begin
        usr_rx_reset_w  = 1'b1;
        core_tx_reset_w = 1'b1;
        stat_rx_aligned = 1'b0;
        clear_inputs();
        reset_and_rx_bringup();
        tx_bringup();
        alignment_loss();
        statistics();
        error_events();
        tx_clear();
        step();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: cmac_link_ctrl.sv
`timescale 1ns/1ps

module cmac_link_ctrl
    import cmac_ctrl_pkg::*;
#(
    parameter int rx_pkt_inc_w  = 3, // MAC rx total-packet increment width
    parameter int rx_byte_inc_w = 7,
    parameter int tx_pkt_inc_w  = 1,
    parameter int tx_byte_inc_w = 6
) (
    input  logic                     gt_txusrclk2,
    input  logic                     usr_rx_reset_w,
    input  logic                     core_tx_reset_w,
    input  logic                     stat_rx_aligned,
    // per-cycle statistics from the MAC
    input  logic [rx_pkt_inc_w-1:0]  stat_rx_total_packets,
    input  logic                     stat_rx_good_packets,
    input  logic [rx_byte_inc_w-1:0] stat_rx_total_bytes,
    input  good_bytes_t              stat_rx_good_bytes,
    input  logic [tx_pkt_inc_w-1:0]  stat_tx_total_packets,
    input  logic                     stat_tx_good_packets,
    input  logic [tx_byte_inc_w-1:0] stat_tx_total_bytes,
    input  good_bytes_t              stat_tx_good_bytes,
    // error and fifo events
    input  logic                     stat_rx_aligned_err,
    input  logic [2:0]               stat_rx_bad_code,
    input  logic [2:0]               stat_rx_bad_fcs,
    input  logic                     stat_rx_bad_preamble,
    input  logic                     stat_rx_bad_sfd,
    input  logic                     tx_ovf,
    input  logic                     tx_unf,
    // MAC control
    output logic                     ctl_rx_enable,
    output logic                     ctl_tx_enable,
    output logic                     ctl_tx_send_lfi,
    output logic                     ctl_tx_send_rfi,
    output count32_t                 rx_total_pkts,
    output count32_t                 rx_good_pkts,
    output count32_t                 rx_total_bytes,
    output count32_t                 rx_good_bytes,
    output count32_t                 tx_total_pkts,
    output count32_t                 tx_good_pkts,
    output count32_t                 tx_total_bytes,
    output count32_t                 tx_good_bytes,
    output count16_t                 align_errors,
    output count16_t                 code_errors,
    output count16_t                 fcs_errors,
    output count16_t                 preamble_errors,
    output count16_t                 sfd_errors,
    output count16_t                 overflow_count,
    output count16_t                 underflow_count
);

    logic rx_aligned_d; // registered alignment, shared by both FSMs

    rx_link_fsm rx_fsm (
        .gt_txusrclk2    (gt_txusrclk2),
        .usr_rx_reset_w  (usr_rx_reset_w),
        .stat_rx_aligned (stat_rx_aligned),
        .rx_aligned_d    (rx_aligned_d),
        .ctl_rx_enable   (ctl_rx_enable)
    );

    tx_link_fsm tx_fsm (
        .gt_txusrclk2    (gt_txusrclk2),
        .core_tx_reset_w (core_tx_reset_w),
        .rx_aligned_d    (rx_aligned_d),
        .ctl_tx_enable   (ctl_tx_enable),
        .ctl_tx_send_lfi (ctl_tx_send_lfi),
        .ctl_tx_send_rfi (ctl_tx_send_rfi)
    );

    stat_accumulator #(
        .pkt_inc_w  (rx_pkt_inc_w),
        .byte_inc_w (rx_byte_inc_w)
    ) rx_stats (
        .gt_txusrclk2    (gt_txusrclk2),
        .count_clear     (usr_rx_reset_w),
        .total_pkts_inc  (stat_rx_total_packets),
        .good_pkts_inc   (stat_rx_good_packets),
        .total_bytes_inc (stat_rx_total_bytes),
        .good_bytes_inc  (stat_rx_good_bytes),
        .total_pkts      (rx_total_pkts),
        .good_pkts       (rx_good_pkts),
        .total_bytes     (rx_total_bytes),
        .good_bytes      (rx_good_bytes)
    );

    stat_accumulator #(
        .pkt_inc_w  (tx_pkt_inc_w),
        .byte_inc_w (tx_byte_inc_w)
    ) tx_stats (
        .gt_txusrclk2    (gt_txusrclk2),
        .count_clear     (core_tx_reset_w), // tx side clears on its own reset
        .total_pkts_inc  (stat_tx_total_packets),
        .good_pkts_inc   (stat_tx_good_packets),
        .total_bytes_inc (stat_tx_total_bytes),
        .good_bytes_inc  (stat_tx_good_bytes),
        .total_pkts      (tx_total_pkts),
        .good_pkts       (tx_good_pkts),
        .total_bytes     (tx_total_bytes),
        .good_bytes      (tx_good_bytes)
    );

    error_counters err_cnt (
        .gt_txusrclk2         (gt_txusrclk2),
        .usr_rx_reset_w       (usr_rx_reset_w),
        .stat_rx_aligned_err  (stat_rx_aligned_err),
        .stat_rx_bad_code     (stat_rx_bad_code),
        .stat_rx_bad_fcs      (stat_rx_bad_fcs),
        .stat_rx_bad_preamble (stat_rx_bad_preamble),
        .stat_rx_bad_sfd      (stat_rx_bad_sfd),
        .tx_ovf               (tx_ovf),
        .tx_unf               (tx_unf),
        .align_errors         (align_errors),
        .code_errors          (code_errors),
        .fcs_errors           (fcs_errors),
        .preamble_errors      (preamble_errors),
        .sfd_errors           (sfd_errors),
        .overflow_count       (overflow_count),
        .underflow_count      (underflow_count)
    );

endmodule

// File: error_counters.sv
`timescale 1ns/1ps

module error_counters
    import cmac_ctrl_pkg::*;
(
    input  logic       gt_txusrclk2,
    input  logic       usr_rx_reset_w,
    input  logic       stat_rx_aligned_err,
    input  logic [2:0] stat_rx_bad_code,
    input  logic [2:0] stat_rx_bad_fcs,
    input  logic       stat_rx_bad_preamble,
    input  logic       stat_rx_bad_sfd,
    input  logic       tx_ovf,
    input  logic       tx_unf,
    output count16_t   align_errors,
    output count16_t   code_errors,
    output count16_t   fcs_errors,
    output count16_t   preamble_errors,
    output count16_t   sfd_errors,
    output count16_t   overflow_count,
    output count16_t   underflow_count
);

    localparam int num_events = 7;

    logic [num_events-1:0] event_hit; // one bit per counter
    count16_t              event_cnt [num_events];

    // multi-lane error inputs count once per cycle
    assign event_hit[0] = stat_rx_aligned_err;
    assign event_hit[1] = |stat_rx_bad_code;
    assign event_hit[2] = |stat_rx_bad_fcs;
    assign event_hit[3] = stat_rx_bad_preamble;
    assign event_hit[4] = stat_rx_bad_sfd;
    assign event_hit[5] = tx_ovf;
    assign event_hit[6] = tx_unf;

    for (genvar i = 0; i < num_events; i++) begin : g_cnt
        always_ff @(posedge gt_txusrclk2) begin
            if (usr_rx_reset_w) begin
                event_cnt[i] <= '0;
            end else if (event_hit[i]) begin
                event_cnt[i] <= event_cnt[i] + 1'b1; // wraps at 16 bits
            end
        end
    end

    assign align_errors    = event_cnt[0];
    assign code_errors     = event_cnt[1];
    assign fcs_errors      = event_cnt[2];
    assign preamble_errors = event_cnt[3];
    assign sfd_errors      = event_cnt[4];
    assign overflow_count  = event_cnt[5];
    assign underflow_count = event_cnt[6];

endmodule

// File: stat_accumulator.sv
`timescale 1ns/1ps

module stat_accumulator
    import cmac_ctrl_pkg::*;
#(
    parameter int pkt_inc_w  = 3,
    parameter int byte_inc_w = 7
) (
    input  logic                  gt_txusrclk2,
    input  logic                  count_clear,
    input  logic [pkt_inc_w-1:0]  total_pkts_inc,
    input  logic                  good_pkts_inc,
    input  logic [byte_inc_w-1:0] total_bytes_inc,
    input  good_bytes_t           good_bytes_inc,
    output count32_t              total_pkts,
    output count32_t              good_pkts,
    output count32_t              total_bytes,
    output count32_t              good_bytes
);

    // increments widened to the accumulator width
    count32_t total_pkts_ext;
    count32_t good_pkts_ext;
    count32_t total_bytes_ext;
    count32_t good_bytes_ext;

    assign total_pkts_ext  = count32_t'(total_pkts_inc);
    assign good_pkts_ext   = count32_t'(good_pkts_inc);
    assign total_bytes_ext = count32_t'(total_bytes_inc);
    assign good_bytes_ext  = count32_t'(good_bytes_inc);

    always_ff @(posedge gt_txusrclk2) begin
        if (count_clear) begin
            total_pkts  <= '0;
            good_pkts   <= '0;
            total_bytes <= '0;
            good_bytes  <= '0;
        end else begin
            // totals wrap on overflow
            total_pkts  <= total_pkts + total_pkts_ext;
            good_pkts   <= good_pkts + good_pkts_ext;
            total_bytes <= total_bytes + total_bytes_ext;
            good_bytes  <= good_bytes + good_bytes_ext;
        end
    end

endmodule

// File: tx_link_fsm.sv
`timescale 1ns/1ps

module tx_link_fsm
    import cmac_ctrl_pkg::*;
(
    input  logic gt_txusrclk2,
    input  logic core_tx_reset_w,
    input  logic rx_aligned_d,
    output logic ctl_tx_enable,
    output logic ctl_tx_send_lfi,
    output logic ctl_tx_send_rfi
);

    link_state_t tx_state;
    logic        tx_reset_done;

    always_ff @(posedge gt_txusrclk2) begin
        if (core_tx_reset_w) begin
            tx_state        <= link_idle;
            tx_reset_done   <= 1'b0;
            ctl_tx_enable   <= 1'b0;
            ctl_tx_send_lfi <= 1'b0;
            ctl_tx_send_rfi <= 1'b0;
        end else begin
            tx_reset_done <= 1'b1;

            case (tx_state)
                link_idle: begin
                    ctl_tx_enable   <= 1'b0;
                    ctl_tx_send_lfi <= 1'b0;
                    ctl_tx_send_rfi <= 1'b0;
                    if (tx_reset_done) begin
                        tx_state <= link_gt_locked;
                    end
                end
                link_gt_locked: begin
                    // tell the far end we are not ready yet
                    ctl_tx_enable   <= 1'b0;
                    ctl_tx_send_lfi <= 1'b1;
                    ctl_tx_send_rfi <= 1'b1;
                    tx_state        <= link_wait_aligned;
                end
                link_wait_aligned: begin
                    if (rx_aligned_d) begin // alignment comes from the rx side
                        tx_state <= link_transfer;
                    end
                end
                link_transfer: begin
                    ctl_tx_enable   <= 1'b1;
                    ctl_tx_send_lfi <= 1'b0;
                    ctl_tx_send_rfi <= 1'b0;
                    if (!rx_aligned_d) begin
                        tx_state <= link_idle;
                    end
                end
                default: tx_state <= link_idle;
            endcase
        end
    end

    // fault signalling and data transmit are mutually exclusive
    property p_no_enable_with_lfi;
        @(posedge gt_txusrclk2) disable iff (core_tx_reset_w)
            !(ctl_tx_enable && ctl_tx_send_lfi);
    endproperty

    a_no_enable_with_lfi: assert property (p_no_enable_with_lfi)
        else $error("ctl_tx_enable and ctl_tx_send_lfi both set");

endmodule

// File: rx_link_fsm.sv
`timescale 1ns/1ps

module rx_link_fsm
    import cmac_ctrl_pkg::*;
(
    input  logic gt_txusrclk2,
    input  logic usr_rx_reset_w,
    input  logic stat_rx_aligned,
    output logic rx_aligned_d,
    output logic ctl_rx_enable
);

    link_state_t rx_state;
    logic        rx_reset_done; // stays set until the next reset

    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            rx_state      <= link_idle;
            rx_reset_done <= 1'b0;
            rx_aligned_d  <= 1'b0;
            ctl_rx_enable <= 1'b0;
        end else begin
            rx_reset_done <= 1'b1;
            rx_aligned_d  <= stat_rx_aligned; // one-cycle registered copy

            case (rx_state)
                link_idle: begin
                    ctl_rx_enable <= 1'b0;
                    if (rx_reset_done) begin
                        rx_state <= link_gt_locked;
                    end
                end
                link_gt_locked: begin
                    ctl_rx_enable <= 1'b1;
                    rx_state      <= link_wait_aligned;
                end
                link_wait_aligned: begin
                    if (rx_aligned_d) begin
                        rx_state <= link_transfer;
                    end
                end
                link_transfer: begin
                    // alignment lost, restart the sequence
                    if (!rx_aligned_d) begin
                        rx_state <= link_idle;
                    end
                end
                default: rx_state <= link_idle;
            endcase
        end
    end

    // core must still be disabled in the cycle after reset release
    property p_rx_disabled_after_reset;
        @(posedge gt_txusrclk2) $fell(usr_rx_reset_w) |=> !ctl_rx_enable;
    endproperty

    a_rx_disabled_after_reset: assert property (p_rx_disabled_after_reset)
        else $error("ctl_rx_enable set in the cycle after rx reset");

endmodule

// File: cmac_ctrl_pkg.sv
package cmac_ctrl_pkg;

    // default counter widths
    parameter int STAT_COUNT_W = 32;
    parameter int ERR_COUNT_W  = 16;

    // width of the good-byte increment the MAC reports per cycle
    parameter int GOOD_BYTES_W = 14;

    // accumulated packet and byte totals
    typedef logic [STAT_COUNT_W-1:0] count32_t;

    // wrapping event counts
    typedef logic [ERR_COUNT_W-1:0] count16_t;

    // per-cycle good-byte increment from the MAC
    typedef logic [GOOD_BYTES_W-1:0] good_bytes_t;

    // bring-up sequence, shared by the rx and tx FSMs
    typedef enum logic [1:0] {
        link_idle         = 2'd0, // waiting for reset release
        link_gt_locked    = 2'd1, // transceiver up, core not yet enabled
        link_wait_aligned = 2'd2, // enabled, waiting for lane alignment
        link_transfer     = 2'd3  // aligned, traffic may flow
    } link_state_t;

endpackage
